/* logic/fuzzy_pkg.sv */
package fuzzy_pkg;

    // ==================================================
    // widths
    // ==================================================

    localparam int CRISP_W  = 8;   // unsigned crisp frequency input
    localparam int GRADE_W  = 8;   // membership grade as an unsigned fraction
    localparam int NUM_SETS = 11;  // neg_gigantic through pos_gigantic

    // ==================================================
    // vector types
    // ==================================================

    typedef logic [CRISP_W-1:0] crisp_t;  // raw crisp sample
    typedef logic [GRADE_W-1:0] grade_t;  // 0 is no membership, GRADE_MAX is full

    localparam grade_t GRADE_MAX = grade_t'((1 << GRADE_W) - 1);  // full membership, 255

    // fuzzy set ids, ordered so that set k has its centre at k times the spacing
    typedef enum logic [3:0] {
        NEG_GIGANTIC = 4'd0,   // centre 0
        NEG_HUGE     = 4'd1,
        NEG_BIG      = 4'd2,
        NEG_MEDIUM   = 4'd3,
        NEG_SMALL    = 4'd4,
        ZERO         = 4'd5,   // middle of the range
        POS_SMALL    = 4'd6,
        POS_MEDIUM   = 4'd7,
        POS_BIG      = 4'd8,
        POS_HUGE     = 4'd9,
        POS_GIGANTIC = 4'd10   // last centre, saturates above
    } fuzzy_set_e;

    // ==================================================
    // grade bundles
    // ==================================================

    // only two neighbouring sets are ever nonzero, so the producer sends just the pair
    typedef struct packed {
        fuzzy_set_e lower_id;     // set k, the centre at or below the input
        grade_t     lower_grade;  // falling grade of set k
        grade_t     upper_grade;  // rising grade of set k+1, 0 when k is the last set
    } fuzzy_pair_t;

    // one grade per set, element index equals the set id
    typedef grade_t [NUM_SETS-1:0] grade_vec_t;

    typedef struct packed {
        fuzzy_set_e winner_id;     // set with the largest grade, lowest id on ties
        grade_t     winner_grade;  // grade of that set
    } fuzzy_result_t;

endpackage

/* logic/membership_eval.sv */
`timescale 1ns/1ps

module membership_eval #(
    parameter int SPACING_LOG2 = 1  // set spacing is 2**SPACING_LOG2, valid 0 to 4
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   freq_valid,  // one-cycle strobe with freq
    input  fuzzy_pkg::crisp_t      freq,
    output logic                   pair_valid,  // one cycle after freq_valid
    output fuzzy_pkg::fuzzy_pair_t pair
);

    // ==================================================
    // segment split
    // ==================================================

    localparam int LAST_SEG = fuzzy_pkg::NUM_SETS - 1;  // index of the last centre
    localparam int RISE_W   = fuzzy_pkg::CRISP_W + fuzzy_pkg::GRADE_W;  // room for the shift
    localparam fuzzy_pkg::crisp_t REM_MASK =
        fuzzy_pkg::crisp_t'((1 << SPACING_LOG2) - 1);  // low bits inside one segment

    fuzzy_pkg::crisp_t      seg_idx;     // input divided by the spacing
    fuzzy_pkg::crisp_t      remainder;   // distance above centre seg_idx
    logic                   saturate;    // at or beyond the last centre
    logic [RISE_W-1:0]      rise_wide;   // remainder scaled up before truncation
    fuzzy_pkg::grade_t      rise_grade;  // grade of the upper set
    fuzzy_pkg::grade_t      fall_grade;  // grade of the lower set
    fuzzy_pkg::fuzzy_pair_t pair_next;   // pair for the current input

    always_comb begin
        seg_idx   = freq >> SPACING_LOG2;  // spacing is a power of two, so a shift divides
        remainder = freq & REM_MASK;       // and a mask keeps the remainder
        saturate  = (seg_idx >= fuzzy_pkg::crisp_t'(LAST_SEG));  // pos_gigantic region

        // remainder is below 2**SPACING_LOG2, so the product stays below 2**GRADE_W
        rise_wide  = {{fuzzy_pkg::GRADE_W{1'b0}}, remainder} << (fuzzy_pkg::GRADE_W - SPACING_LOG2);
        rise_grade = fuzzy_pkg::grade_t'(rise_wide);       // keep the low GRADE_W bits
        fall_grade = fuzzy_pkg::GRADE_MAX - rise_grade;   // complement, so the pair sums to max
    end

    // ==================================================
    // pair forming
    // ==================================================

    always_comb begin
        if (saturate) begin
            pair_next.lower_id    = fuzzy_pkg::POS_GIGANTIC;  // top set takes everything
            pair_next.lower_grade = fuzzy_pkg::GRADE_MAX;     // full membership
            pair_next.upper_grade = '0;                       // there is no set above it
        end else begin
            // seg_idx is below LAST_SEG here, so it fits the set id width
            pair_next.lower_id    =
                fuzzy_pkg::fuzzy_set_e'(seg_idx[$bits(fuzzy_pkg::fuzzy_set_e)-1:0]);
            pair_next.lower_grade = fall_grade;  // set k falls as the input moves away
            pair_next.upper_grade = rise_grade;  // set k+1 rises toward its centre
        end
    end

    // ==================================================
    // output register
    // ==================================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pair_valid <= 1'b0;        // nothing in flight after reset
        end else begin
            pair_valid <= freq_valid;  // strobe follows the data by one cycle
        end
    end

    always_ff @(posedge clk) begin
        if (freq_valid) begin
            pair <= pair_next;  // payload only moves with its strobe
        end
    end

endmodule

/* logic/grade_vector_reg.sv */
`timescale 1ns/1ps

module grade_vector_reg (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   pair_valid,  // one-cycle strobe with pair
    input  fuzzy_pkg::fuzzy_pair_t pair,
    output logic                   vec_valid,   // one cycle after pair_valid
    output fuzzy_pkg::grade_vec_t  grades       // held until the next vec_valid
);

    // ==================================================
    // slot decode
    // ==================================================

    logic [fuzzy_pkg::NUM_SETS-1:0] lower_hit;    // one-hot slot of set k
    logic [fuzzy_pkg::NUM_SETS-1:0] upper_hit;    // one-hot slot of set k+1
    fuzzy_pkg::grade_vec_t          grades_next;  // expanded vector

    always_comb begin
        lower_hit = {{(fuzzy_pkg::NUM_SETS-1){1'b0}}, 1'b1} << pair.lower_id;  // one-hot of k
        upper_hit = lower_hit << 1;  // pos_gigantic shifts out, so no slot above the top set
    end

    // ==================================================
    // vector expansion
    // ==================================================

    always_comb begin
        for (int i = 0; i < fuzzy_pkg::NUM_SETS; i++) begin
            if (lower_hit[i]) begin
                grades_next[i] = pair.lower_grade;  // falling side of the bracket
            end else if (upper_hit[i]) begin
                grades_next[i] = pair.upper_grade;  // rising side of the bracket
            end else begin
                grades_next[i] = '0;  // every set outside the bracket has no membership
            end
        end
    end

    // ==================================================
    // held vector
    // ==================================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vec_valid <= 1'b0;        // no item after reset
        end else begin
            vec_valid <= pair_valid;  // one-cycle stage delay
        end
    end

    // the whole vector is rewritten on each strobe
    // so stale grades from the last item never survive
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            grades <= '0;  // outputs read all zero until the first item
        end else if (pair_valid) begin
            grades <= grades_next;  // load, then hold while the strobe is low
        end
    end

endmodule

/* logic/winner_select.sv */
`timescale 1ns/1ps

module winner_select (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     vec_valid,    // one-cycle strobe with grades
    input  fuzzy_pkg::grade_vec_t    grades,
    output logic                     fuzzy_valid,  // one cycle after vec_valid
    output fuzzy_pkg::fuzzy_result_t result        // held until the next fuzzy_valid
);

    // ==================================================
    // maximum scan
    // ==================================================

    fuzzy_pkg::fuzzy_set_e best_id;     // running winner
    fuzzy_pkg::grade_t     best_grade;  // grade of the running winner

    // scans upward from set 0 and replaces only on a strictly larger grade
    // so on a tie the lower set id keeps the win
    always_comb begin
        best_id    = fuzzy_pkg::NEG_GIGANTIC;  // start at the lowest set
        best_grade = grades[0];
        for (int i = 1; i < fuzzy_pkg::NUM_SETS; i++) begin
            if (grades[i] > best_grade) begin
                best_id    = fuzzy_pkg::fuzzy_set_e'(i);  // i is always a legal set id
                best_grade = grades[i];
            end
        end
    end

    // ==================================================
    // result register
    // ==================================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fuzzy_valid <= 1'b0;       // idle after reset
        end else begin
            fuzzy_valid <= vec_valid;  // last stage, third cycle after the input
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result <= '0;  // id neg_gigantic with grade 0 until the first item
        end else if (vec_valid) begin
            result.winner_id    <= best_id;     // set chosen for the rule base
            result.winner_grade <= best_grade;  // its membership
        end
    end

endmodule

/* logic/fuzzifier_top.sv */
`timescale 1ns/1ps

module fuzzifier_top #(
    parameter int SPACING_LOG2 = 1  // default spacing 2, centres at 0, 2, 4 and up to 20
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     freq_valid,   // one-cycle strobe, no back-pressure
    input  fuzzy_pkg::crisp_t        freq,
    output logic                     fuzzy_valid,  // three cycles after freq_valid
    output fuzzy_pkg::grade_vec_t    grades,       // full set of grades, held
    output fuzzy_pkg::fuzzy_result_t result        // winning set and grade, held
);

    // ==================================================
    // stage links
    // ==================================================

    logic                   pair_valid;  // stage 1 strobe
    fuzzy_pkg::fuzzy_pair_t pair;        // bracketing pair from stage 1
    logic                   vec_valid;   // stage 2 strobe

    // stage 1 finds the two sets around the input and their grades
    membership_eval #(
        .SPACING_LOG2 (SPACING_LOG2)
    ) u_membership_eval (
        .clk        (clk),
        .rst_n      (rst_n),
        .freq_valid (freq_valid),
        .freq       (freq),
        .pair_valid (pair_valid),
        .pair       (pair)
    );

    // stage 2 spreads the pair over all eleven slots and holds it
    grade_vector_reg u_grade_vector_reg (
        .clk        (clk),
        .rst_n      (rst_n),
        .pair_valid (pair_valid),
        .pair       (pair),
        .vec_valid  (vec_valid),
        .grades     (grades)
    );

    // stage 3 reads the held vector, which also drives the top-level grades port
    winner_select u_winner_select (
        .clk         (clk),
        .rst_n       (rst_n),
        .vec_valid   (vec_valid),
        .grades      (grades),
        .fuzzy_valid (fuzzy_valid),
        .result      (result)
    );

endmodule

/* test/fuzzifier_model.svh */
`ifndef FUZZIFIER_MODEL_SVH
`define FUZZIFIER_MODEL_SVH

// ==================================================
// reference grades
// ==================================================

// grade vector that the eleven triangular sets give for one crisp value
function automatic fuzzy_pkg::grade_vec_t model_grades(
    input fuzzy_pkg::crisp_t value,
    input int                spacing_log2
);
    fuzzy_pkg::grade_vec_t vec;
    int spacing;      // distance between neighbouring centres
    int last_centre;  // centre of pos_gigantic
    int k;            // set at or below the input
    int d;            // distance above centre k
    int rise;         // grade of set k+1
    vec         = '0;                                  // sets outside the bracket stay at 0
    spacing     = 1 << spacing_log2;
    last_centre = (fuzzy_pkg::NUM_SETS - 1) * spacing;
    if (int'(value) >= last_centre) begin
        vec[fuzzy_pkg::NUM_SETS-1] = fuzzy_pkg::GRADE_MAX;  // saturated at the top set
    end else begin
        k    = int'(value) / spacing;
        d    = int'(value) % spacing;
        rise = d * (1 << (fuzzy_pkg::GRADE_W - spacing_log2));  // remainder as a fraction
        vec[k]     = fuzzy_pkg::grade_t'(int'(fuzzy_pkg::GRADE_MAX) - rise);
        vec[k + 1] = fuzzy_pkg::grade_t'(rise);
    end
    return vec;
endfunction

// ==================================================
// reference winner
// ==================================================

// walks downward and takes equal grades too, so the lowest id ends up winning a tie
function automatic fuzzy_pkg::fuzzy_result_t model_winner(
    input fuzzy_pkg::grade_vec_t vec
);
    fuzzy_pkg::fuzzy_result_t res;
    res.winner_id    = fuzzy_pkg::POS_GIGANTIC;
    res.winner_grade = vec[fuzzy_pkg::NUM_SETS-1];
    for (int i = fuzzy_pkg::NUM_SETS - 2; i >= 0; i--) begin
        if (vec[i] >= res.winner_grade) begin
            res.winner_id    = fuzzy_pkg::fuzzy_set_e'(i);
            res.winner_grade = vec[i];
        end
    end
    return res;
endfunction

`endif

/* test/fuzzifier_tb.sv */
`timescale 1ns/1ps

module fuzzifier_tb;

    `include "fuzzifier_model.svh"

    localparam int SPACING_LOG2  = 1;                 // default spacing of 2
    localparam int CLK_PERIOD    = 40;
    localparam int RANDOM_COUNT  = 64;                // back-to-back random items
    localparam int HOLD_COUNT    = 24;                // items with idle gaps
    localparam int TOTAL_STROBES = 11 + 10 + 235 + RANDOM_COUNT + HOLD_COUNT;
    localparam int WATCHDOG_NS   = 2 * (TOTAL_STROBES + 20) * CLK_PERIOD;

    logic                     clk;
    logic                     rst_n;
    logic                     freq_valid;
    fuzzy_pkg::crisp_t        freq;
    logic                     fuzzy_valid;
    fuzzy_pkg::grade_vec_t    grades;
    fuzzy_pkg::fuzzy_result_t result;

    logic                     strobe_d1;   // input strobe delayed to the grade load edge
    logic                     strobe_d2;   // delayed to the result load edge
    logic                     strobe_d3;   // lines up with the expected fuzzy_valid
    fuzzy_pkg::grade_vec_t    exp_grades;  // what grades should hold right now
    fuzzy_pkg::fuzzy_result_t exp_result;  // what result should hold right now
    fuzzy_pkg::grade_vec_t    grade_q[$];
    fuzzy_pkg::fuzzy_result_t result_q[$];

    int seed = 34;
    int error_count = 0;
    int sent_count = 0;
    int recv_count;
    int tests_run = 0;
    int tests_failed = 0;
    int test_start_errors = 0;

    fuzzifier_top #(
        .SPACING_LOG2 (SPACING_LOG2)
    ) uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .freq_valid  (freq_valid),
        .freq        (freq),
        .fuzzy_valid (fuzzy_valid),
        .grades      (grades),
        .result      (result)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ==================================================
    // expected pipeline
    // ==================================================

    always @(posedge clk) begin
        if (!rst_n) begin
            strobe_d1  <= 1'b0;
            strobe_d2  <= 1'b0;
            strobe_d3  <= 1'b0;
            exp_grades <= '0;  // outputs read zero after reset
            exp_result <= '0;
            recv_count <= 0;
        end else begin
            strobe_d1 <= freq_valid;
            strobe_d2 <= strobe_d1;
            strobe_d3 <= strobe_d2;
            if (strobe_d1) begin  // the grade vector loads two edges after the input
                exp_grades <= grade_q.pop_front();
            end
            if (strobe_d2) begin  // and the winner one edge later
                exp_result <= result_q.pop_front();
            end
            if (fuzzy_valid) begin
                recv_count <= recv_count + 1;  // counts items seen at the output
            end
        end
    end

    // ==================================================
    // assertions
    // ==================================================

    valid_timing: assert property (@(posedge clk) disable iff (!rst_n)
        fuzzy_valid == strobe_d3)
        else begin
            $display("Mismatch at %0d ns: fuzzy_valid expected %0b, actual %0b",
                     $time, $sampled(strobe_d3), $sampled(fuzzy_valid));
            error_count++;
        end

    grades_value: assert property (@(posedge clk) disable iff (!rst_n)
        grades == exp_grades)
        else begin
            $display("Mismatch at %0d ns: grades expected %h, actual %h",
                     $time, $sampled(exp_grades), $sampled(grades));
            error_count++;
        end

    result_value: assert property (@(posedge clk) disable iff (!rst_n)
        result == exp_result)
        else begin
            $display("Mismatch at %0d ns: result expected %h, actual %h",
                     $time, $sampled(exp_result), $sampled(result));
            error_count++;
        end

    // grades may only move on the edge where the vector stage takes an item
    grades_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !strobe_d1 |=> $stable(grades))
        else begin
            $display("error at %0d ns: grades changed with no item arriving", $time);
            error_count++;
        end

    result_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !fuzzy_valid |-> $stable(result))
        else begin
            $display("error at %0d ns: result changed while fuzzy_valid was low", $time);
            error_count++;
        end

    // ==================================================
    // stimulus helpers
    // ==================================================

    // strobe one value on the next edge and queue what it should produce
    task automatic send_item(input fuzzy_pkg::crisp_t value);
        fuzzy_pkg::grade_vec_t vec;
        vec = model_grades(value, SPACING_LOG2);
        @(posedge clk);
        grade_q.push_back(vec);
        result_q.push_back(model_winner(vec));
        freq_valid <= 1'b1;
        freq       <= value;
        sent_count++;
    endtask

    task automatic idle_cycles(input int count);
        repeat (count) begin
            @(posedge clk);
            freq_valid <= 1'b0;
        end
    endtask

    // wait for every item in flight to reach the output, the watchdog covers a stall
    task automatic drain_pipeline();
        idle_cycles(1);
        while (recv_count != sent_count) begin
            @(posedge clk);
        end
        @(posedge clk);  // lets the assertions sample the last item
    endtask

    task automatic close_test(input string name);
        int errors;
        errors = error_count - test_start_errors;
        tests_run++;
        if (errors != 0) begin
            tests_failed++;
        end
        $display("test %-16s %s (%0d errors)", name, (errors == 0) ? "ok" : "failed", errors);
        test_start_errors = error_count;
    endtask

    // ==================================================
    // test sequence
    // ==================================================

    initial begin
        int gap;
        rst_n      = 1'b0;
        freq_valid = 1'b0;
        freq       = '0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        idle_cycles(4);  // outputs must stay at zero with no strobe
        close_test("reset");

        for (int c = 0; c <= 20; c += 2) begin
            send_item(fuzzy_pkg::crisp_t'(c));
        end
        drain_pipeline();
        close_test("centres");

        for (int v = 1; v <= 19; v += 2) begin
            send_item(fuzzy_pkg::crisp_t'(v));  // halfway points, upper set wins
        end
        for (int v = 21; v <= 255; v++) begin
            send_item(fuzzy_pkg::crisp_t'(v));  // saturated range
        end
        drain_pipeline();
        close_test("between_centres");

        repeat (RANDOM_COUNT) begin
            send_item(fuzzy_pkg::crisp_t'($random(seed)));
        end
        drain_pipeline();
        close_test("throughput");

        repeat (HOLD_COUNT) begin
            send_item(fuzzy_pkg::crisp_t'($random(seed)));
            gap = 1 + ($random(seed) & 32'h3);  // one to four idle cycles
            idle_cycles(gap);
        end
        drain_pipeline();
        close_test("holding");

        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout after %0d ns, the pipeline stopped producing results", WATCHDOG_NS);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

/* fuzzifier_top.f */
+incdir+test
logic/fuzzy_pkg.sv
logic/membership_eval.sv
logic/grade_vector_reg.sv
logic/winner_select.sv
logic/fuzzifier_top.sv
test/fuzzifier_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile the fuzzifier testbench with Verilator, run it, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f fuzzifier_top.f --top-module fuzzifier_tb -Mdir obj_dir -o fuzzifier_sim \
    > build.log 2>&1 \
    && ./obj_dir/fuzzifier_sim > sim.log 2>&1 \
    ; grep -q "^ALL CHECKS PASSED$" sim.log 2>/dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }
